// ==== source/panel_pkg.sv ====
package panel_pkg;

    typedef logic [15:0] word_t;       // Bus, switch and LED word
    typedef logic [13:0] imem_addr_t;  // 16K instruction words
    typedef logic [14:0] dmem_addr_t;  // 32K data words

    localparam int    IO_SPACE_BIT = 15;       // Set means I/O, clear means data memory
    localparam word_t IO_LED_ADDR  = 16'h8000;
    localparam word_t IO_SW_ADDR   = 16'h8001;

    typedef struct packed {
        dmem_addr_t raddr;
        dmem_addr_t waddr;
        word_t      wdata;
        logic       we;
    } dmem_req_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  rd;     // Read strobe
        logic  wr;     // Write strobe
    } io_req_t;

    typedef struct packed {
        imem_addr_t imem_addr;
        dmem_req_t  dmem;
        io_req_t    io;
    } core_req_t;

    typedef struct packed {
        word_t imem_data;
        word_t dmem_data;
        word_t io_data;
    } core_rsp_t;

    typedef struct packed {
        word_t      pc_display;
        logic [3:0] dp;          // Debug points, dp[3] leftmost
    } core_status_t;

    typedef enum logic [1:0] {
        TGT_DMEM,
        TGT_IMEM,
        TGT_IO
    } panel_target_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_WAIT,
        READ_DONE,
        WRITE,
        WRITE_DONE
    } panel_op_t;

    typedef struct packed {
        logic          active;   // Panel owns its target path
        panel_target_t target;
        word_t         addr;
        word_t         wdata;
        logic          rd;
        logic          wr;
    } panel_bus_t;

    typedef struct packed {
        logic [3:0][3:0] digits;  // digits[3] is leftmost
        logic [3:0]      dp;
    } display_t;

endpackage

// ==== source/button_debouncer.sv ====
module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int LONG_CYCLES     = 1024
) (
    input  logic clk,
    input  logic reset,
    input  logic button,
    output logic press_pulse,
    output logic short_pulse,
    output logic long_pulse
);
    localparam int SW = $clog2(DEBOUNCE_CYCLES + 1);
    localparam int HW = $clog2(LONG_CYCLES + 1);

    logic [1:0]    sync_q;      // Two-flop synchronizer
    logic          level;       // Debounced button level
    logic [SW-1:0] stable_cnt;
    logic [HW-1:0] hold_cnt;
    logic          long_seen;   // Long pulse already given for this press
    logic          flip;

    // Raw level has differed long enough to take it
    assign flip = (sync_q[1] != level) && (stable_cnt == SW'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q     <= '0;
            level      <= 1'b0;
            stable_cnt <= '0;
        end else begin
            sync_q <= {sync_q[0], button};
            if (sync_q[1] == level) begin
                stable_cnt <= '0;            // Bounce back, start over
            end else if (flip) begin
                stable_cnt <= '0;
                level      <= sync_q[1];
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_cnt    <= '0;
            long_seen   <= 1'b0;
            press_pulse <= 1'b0;
            short_pulse <= 1'b0;
            long_pulse  <= 1'b0;
        end else begin
            press_pulse <= flip && sync_q[1];
            short_pulse <= flip && !sync_q[1] && !long_seen;  // Release without long
            long_pulse  <= 1'b0;
            if (!level) begin
                hold_cnt  <= '0;
                long_seen <= 1'b0;
            end else if (!long_seen) begin
                if (hold_cnt == HW'(LONG_CYCLES - 1)) begin
                    long_pulse <= 1'b1;
                    long_seen  <= 1'b1;
                end else begin
                    hold_cnt <= hold_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/run_control.sv ====
module run_control #(
    parameter int SLOW_DIV = 1000
) (
    input  logic clk,
    input  logic reset,
    input  logic speed_pulse,
    input  logic panel_mode,
    output logic core_clk_en,
    output logic bus_clk_en
);
    localparam int DW = $clog2(SLOW_DIV + 1);

    logic          speed_slow;  // 1 = slow stepping
    logic [DW-1:0] div_cnt;
    logic          slow_en;

    assign slow_en = (div_cnt == DW'(SLOW_DIV - 1));  // One cycle in SLOW_DIV

    always_ff @(posedge clk) begin
        if (reset) begin
            speed_slow <= 1'b0;
            div_cnt    <= '0;
        end else begin
            if (speed_pulse) begin
                speed_slow <= ~speed_slow;
            end
            // Free running so every window of SLOW_DIV holds one enable
            if (slow_en) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Core frozen in panel mode, running through reset otherwise
    assign core_clk_en = panel_mode ? 1'b0 : ((speed_slow ? slow_en : 1'b1) | reset);

    // Memories and I/O run full rate while the panel drives them
    assign bus_clk_en = panel_mode | core_clk_en;

endmodule

// ==== source/front_panel.sv ====
module front_panel
    import panel_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         enter_pulse,    // Short press in normal mode
    input  logic         toggle_pulse,   // Short press in panel mode
    input  logic         exit_pulse,     // Long hold
    input  logic         examine_pulse,
    input  logic         deposit_pulse,
    input  word_t        sw,
    input  word_t        panel_rdata,
    input  word_t        io_leds,
    input  core_status_t core_status,
    output logic         panel_mode,
    output panel_bus_t   panel_bus,
    output word_t        led,
    output display_t     display
);
    logic          mem_select;  // 1 = instruction space, 0 = data/IO
    panel_op_t     op;
    word_t         addr;        // Examine/deposit address
    word_t         data_q;      // Word shown on the LEDs
    panel_target_t target;

    // Target decoded once, used by strobes and readback alike
    always_comb begin
        if (mem_select) begin
            target = TGT_IMEM;
        end else if (addr[IO_SPACE_BIT]) begin
            target = TGT_IO;
        end else begin
            target = TGT_DMEM;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            panel_mode <= 1'b0;
            mem_select <= 1'b0;
            op         <= IDLE;
        end else if (!panel_mode) begin
            op <= IDLE;
            if (enter_pulse) begin
                panel_mode <= 1'b1;
                mem_select <= 1'b0;          // Always start in data/IO space
            end
        end else if (exit_pulse) begin
            panel_mode <= 1'b0;
            op         <= IDLE;              // Abandon any access in flight
        end else begin
            case (op)
                IDLE: begin
                    if (examine_pulse) begin
                        op <= READ_WAIT;
                    end else if (deposit_pulse) begin
                        op <= WRITE;
                    end else if (toggle_pulse) begin
                        mem_select <= ~mem_select;
                    end
                end
                READ_WAIT:  op <= READ_DONE;     // Memory registers the word
                READ_DONE:  op <= IDLE;
                WRITE:      op <= WRITE_DONE;
                WRITE_DONE: op <= IDLE;
                default:    op <= IDLE;
            endcase
        end
    end

    // Address and LED word
    always_ff @(posedge clk) begin
        if (panel_mode && op == IDLE && examine_pulse) begin
            addr <= sw;                      // Examine loads address from switches
        end
        if (op == WRITE_DONE) begin
            addr <= addr + 1'b1;             // Deposit auto-increment
        end
        if (op == READ_DONE) begin
            data_q <= panel_rdata;
        end else if (op == WRITE) begin
            data_q <= sw;                    // Echo what was written
        end
    end

    always_comb begin
        panel_bus.active = panel_mode;
        panel_bus.target = target;
        panel_bus.addr   = addr;
        panel_bus.wdata  = sw;
        panel_bus.rd     = (op == READ_WAIT);
        panel_bus.wr     = (op == WRITE);
    end

    assign led = panel_mode ? data_q : io_leds;

    always_comb begin
        if (panel_mode) begin
            display.digits = addr;
            display.dp     = {mem_select, ~mem_select, 2'b00};  // dp3 imem, dp2 data/IO
        end else begin
            display.digits = core_status.pc_display;
            display.dp     = core_status.dp;
        end
    end

endmodule

// ==== source/bus_router.sv ====
module bus_router
    import panel_pkg::*;
(
    input  panel_bus_t panel_bus,
    input  core_req_t  core_req,
    input  word_t      imem_rdata,
    input  word_t      dmem_rdata,
    input  word_t      io_rdata,
    output imem_addr_t imem_raddr,
    output imem_addr_t imem_waddr,
    output logic       imem_we,
    output word_t      imem_wdata,
    output dmem_req_t  dmem_req,
    output io_req_t    io_req,
    output core_rsp_t  core_rsp,
    output word_t      panel_rdata
);
    logic panel_imem;
    logic panel_dmem;
    logic panel_io;

    assign panel_imem = panel_bus.active && panel_bus.target == TGT_IMEM;
    assign panel_dmem = panel_bus.active && panel_bus.target == TGT_DMEM;
    assign panel_io   = panel_bus.active && panel_bus.target == TGT_IO;

    // Only the panel writes instruction memory
    assign imem_raddr = panel_imem ? panel_bus.addr[13:0] : core_req.imem_addr;
    assign imem_waddr = panel_bus.addr[13:0];
    assign imem_wdata = panel_bus.wdata;
    assign imem_we    = panel_imem && panel_bus.wr;

    always_comb begin
        dmem_req = core_req.dmem;
        if (panel_dmem) begin
            dmem_req.raddr = panel_bus.addr[14:0];
            dmem_req.waddr = panel_bus.addr[14:0];
            dmem_req.wdata = panel_bus.wdata;
            dmem_req.we    = panel_bus.wr;
        end
    end

    always_comb begin
        io_req = core_req.io;
        if (panel_io) begin
            io_req.addr  = panel_bus.addr;
            io_req.wdata = panel_bus.wdata;
            io_req.rd    = panel_bus.rd;
            io_req.wr    = panel_bus.wr;
        end
    end

    assign core_rsp = '{imem_data: imem_rdata, dmem_data: dmem_rdata, io_data: io_rdata};

    always_comb begin
        case (panel_bus.target)
            TGT_IMEM: panel_rdata = imem_rdata;
            TGT_IO:   panel_rdata = io_rdata;
            default:  panel_rdata = dmem_rdata;
        endcase
    end

endmodule

// ==== source/word_memory.sv ====
module word_memory
    import panel_pkg::*;
#(
    parameter type addr_t = imem_addr_t
) (
    input  logic  clk,
    input  logic  clk_en,
    input  logic  we,
    input  addr_t raddr,
    input  addr_t waddr,
    input  word_t wdata,
    output word_t rdata
);
    localparam int DEPTH = 2 ** $bits(addr_t);

    word_t mem [DEPTH];

    // Registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (we) begin
                mem[waddr] <= wdata;
            end
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== source/io_registers.sv ====
module io_registers
    import panel_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    clk_en,
    input  io_req_t io_req,
    input  word_t   sw,
    output word_t   io_rdata,
    output word_t   leds
);

    always_ff @(posedge clk) begin
        if (reset) begin
            leds <= '0;
        end else if (clk_en && io_req.wr && io_req.addr == IO_LED_ADDR) begin
            leds <= io_req.wdata;
        end
    end

    // Read data lands one edge after the strobe, then holds
    always_ff @(posedge clk) begin
        if (clk_en && io_req.rd) begin
            case (io_req.addr)
                IO_LED_ADDR: io_rdata <= leds;
                IO_SW_ADDR:  io_rdata <= sw;
                default:     io_rdata <= '0;   // Unmapped reads zero
            endcase
        end
    end

endmodule

// ==== source/sevenseg_scan.sv ====
module sevenseg_scan
    import panel_pkg::*;
#(
    parameter int SCAN_DIV = 100000
) (
    input  logic       clk,
    input  logic       reset,
    input  display_t   display,
    output logic [6:0] seg,      // {g,f,e,d,c,b,a}, active low
    output logic       dp,
    output logic [3:0] an
);
    localparam int DW = $clog2(SCAN_DIV + 1);

    logic [DW-1:0] div_cnt;
    logic [1:0]    digit_sel;
    logic [3:0]    nibble;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            digit_sel <= '0;
        end else if (div_cnt == DW'(SCAN_DIV - 1)) begin
            div_cnt   <= '0;
            digit_sel <= digit_sel + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign nibble = display.digits[digit_sel];
    assign an     = ~(4'b0001 << digit_sel);    // One anode low at a time
    assign dp     = ~display.dp[digit_sel];

    always_comb begin
        case (nibble)
            4'h0: seg = 7'h40;
            4'h1: seg = 7'h79;
            4'h2: seg = 7'h24;
            4'h3: seg = 7'h30;
            4'h4: seg = 7'h19;
            4'h5: seg = 7'h12;
            4'h6: seg = 7'h02;
            4'h7: seg = 7'h78;
            4'h8: seg = 7'h00;
            4'h9: seg = 7'h10;
            4'hA: seg = 7'h08;
            4'hB: seg = 7'h03;   // Lower case b
            4'hC: seg = 7'h46;
            4'hD: seg = 7'h21;   // Lower case d
            4'hE: seg = 7'h06;
            default: seg = 7'h0E;
        endcase
    end

endmodule

// ==== source/panel_top.sv ====
module panel_top
    import panel_pkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 500000,
    parameter int LONG_CYCLES     = 100000000,
    parameter int SLOW_DIV        = 100000000,
    parameter int SCAN_DIV        = 100000
) (
    input  logic         clk,
    input  logic         reset,
    input  word_t        sw,
    input  logic         btn_speed,
    input  logic         btn_mode,
    input  logic         btn_examine,
    input  logic         btn_deposit,
    input  core_req_t    core_req,
    input  core_status_t core_status,
    output core_rsp_t    core_rsp,
    output logic         core_clk_en,
    output word_t        led,
    output logic [6:0]   seg,
    output logic         dp,
    output logic [3:0]   an
);
    logic       speed_pulse;
    logic       mode_short;    // Enter, or toggle space inside panel mode
    logic       mode_long;     // Exit panel mode
    logic       examine_pulse;
    logic       deposit_pulse;
    logic       panel_mode;
    logic       bus_clk_en;
    panel_bus_t panel_bus;
    word_t      panel_rdata;
    imem_addr_t imem_raddr;
    imem_addr_t imem_waddr;
    logic       imem_we;
    word_t      imem_wdata;
    word_t      imem_rdata;
    dmem_req_t  dmem_req;
    word_t      dmem_rdata;
    io_req_t    io_req;
    word_t      io_rdata;
    word_t      io_leds;
    display_t   display;

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .LONG_CYCLES(LONG_CYCLES)) speed_db (
        .clk(clk), .reset(reset), .button(btn_speed),
        .press_pulse(speed_pulse), .short_pulse(), .long_pulse()
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .LONG_CYCLES(LONG_CYCLES)) mode_db (
        .clk(clk), .reset(reset), .button(btn_mode),
        .press_pulse(), .short_pulse(mode_short), .long_pulse(mode_long)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .LONG_CYCLES(LONG_CYCLES)) examine_db (
        .clk(clk), .reset(reset), .button(btn_examine),
        .press_pulse(examine_pulse), .short_pulse(), .long_pulse()
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .LONG_CYCLES(LONG_CYCLES)) deposit_db (
        .clk(clk), .reset(reset), .button(btn_deposit),
        .press_pulse(deposit_pulse), .short_pulse(), .long_pulse()
    );

    run_control #(.SLOW_DIV(SLOW_DIV)) run_ctl (
        .clk(clk), .reset(reset), .speed_pulse(speed_pulse), .panel_mode(panel_mode),
        .core_clk_en(core_clk_en), .bus_clk_en(bus_clk_en)
    );

    front_panel panel (
        .clk(clk), .reset(reset),
        .enter_pulse(mode_short), .toggle_pulse(mode_short), .exit_pulse(mode_long),
        .examine_pulse(examine_pulse), .deposit_pulse(deposit_pulse),
        .sw(sw), .panel_rdata(panel_rdata), .io_leds(io_leds), .core_status(core_status),
        .panel_mode(panel_mode), .panel_bus(panel_bus), .led(led), .display(display)
    );

    bus_router router (
        .panel_bus(panel_bus), .core_req(core_req),
        .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata), .io_rdata(io_rdata),
        .imem_raddr(imem_raddr), .imem_waddr(imem_waddr), .imem_we(imem_we),
        .imem_wdata(imem_wdata), .dmem_req(dmem_req), .io_req(io_req),
        .core_rsp(core_rsp), .panel_rdata(panel_rdata)
    );

    word_memory #(.addr_t(imem_addr_t)) imem (
        .clk(clk), .clk_en(bus_clk_en), .we(imem_we),
        .raddr(imem_raddr), .waddr(imem_waddr), .wdata(imem_wdata), .rdata(imem_rdata)
    );

    word_memory #(.addr_t(dmem_addr_t)) dmem (
        .clk(clk), .clk_en(bus_clk_en), .we(dmem_req.we),
        .raddr(dmem_req.raddr), .waddr(dmem_req.waddr), .wdata(dmem_req.wdata),
        .rdata(dmem_rdata)
    );

    io_registers io_regs (
        .clk(clk), .reset(reset), .clk_en(bus_clk_en), .io_req(io_req), .sw(sw),
        .io_rdata(io_rdata), .leds(io_leds)
    );

    sevenseg_scan #(.SCAN_DIV(SCAN_DIV)) scan (
        .clk(clk), .reset(reset), .display(display), .seg(seg), .dp(dp), .an(an)
    );

endmodule

// ==== verif/panel_props.sv ====
module panel_props
    import panel_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       panel_mode,
    input logic       deposit_pulse,
    input panel_bus_t panel_bus,
    input panel_op_t  op
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;  // Failed assertion attempts

    // One cycle per strobe keeps reads and writes apart
    strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (panel_bus.rd || panel_bus.wr) |=> !(panel_bus.rd || panel_bus.wr))
        else begin
            fail_count++;
            $error("panel strobe held longer than one cycle");
        end

    // Strobes belong to panel mode only
    strobe_in_panel: assert property (@(posedge clk) disable iff (reset)
        !panel_mode |-> !(panel_bus.rd || panel_bus.wr))
        else begin
            fail_count++;
            $error("panel strobe high outside panel mode");
        end

    wr_after_deposit: assert property (@(posedge clk) disable iff (reset)
        panel_bus.wr |-> $past(op == IDLE && deposit_pulse))  // WRITE entered from IDLE only
        else begin
            fail_count++;
            $error("panel write strobe without an accepted deposit");
        end

endmodule

bind front_panel panel_props props0 (
    .clk(clk), .reset(reset), .panel_mode(panel_mode), .deposit_pulse(deposit_pulse),
    .panel_bus(panel_bus), .op(op)
);

// ==== verif/panel_tb.sv ====
module panel_tb
    import panel_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int LONG_CYCLES     = 40;
    localparam int SLOW_DIV        = 4;
    localparam int SCAN_DIV        = 2;
    localparam int SHORT_HOLD      = 12;   // Well under LONG_CYCLES
    localparam int LONG_HOLD       = 60;   // Well over LONG_CYCLES
    localparam int SETTLE          = 20;   // Release debounce plus sequencer
    localparam int CYCLES_PER_LINE = 400;
    localparam string STIM_FILE    = "verif/panel_stim.txt";

    // Button bits
    localparam int BTN_SPEED   = 0;
    localparam int BTN_MODE    = 1;
    localparam int BTN_EXAMINE = 2;
    localparam int BTN_DEPOSIT = 3;

    // Stim op codes
    localparam int OP_CORE_WR = 0;
    localparam int OP_CORE_RD = 1;
    localparam int OP_ENTER   = 2;
    localparam int OP_TOGGLE  = 3;
    localparam int OP_EXIT    = 4;
    localparam int OP_EXAMINE = 5;
    localparam int OP_DEPOSIT = 6;
    localparam int OP_SETADDR = 7;
    localparam int OP_SPEED   = 8;

    localparam word_t      CORE_PC = 16'hC0DE;  // Core status shown in normal mode
    localparam logic [3:0] CORE_DP = 4'b0001;

    logic         clk = 1'b0;
    logic         reset;
    word_t        sw;
    logic [3:0]   btn;
    core_req_t    core_req;
    core_status_t core_status;
    core_rsp_t    core_rsp;
    logic         core_clk_en;
    word_t        led;
    logic [6:0]   seg;
    logic         dp;
    logic [3:0]   an;

    int          op_col[$];                 // Stim columns
    word_t       sw_col[$];
    word_t       exp_col[$];
    int          n_lines = 0;
    int          errors  = 0;
    int          checks  = 0;
    logic [31:0] lfsr_state = 32'h682e_a17a;
    word_t       dmem_model [word_t];       // Words the core wrote

    always #5 clk = ~clk;

    panel_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .LONG_CYCLES(LONG_CYCLES),
        .SLOW_DIV(SLOW_DIV),
        .SCAN_DIV(SCAN_DIV)
    ) dut0 (
        .clk(clk), .reset(reset), .sw(sw),
        .btn_speed(btn[BTN_SPEED]), .btn_mode(btn[BTN_MODE]),
        .btn_examine(btn[BTN_EXAMINE]), .btn_deposit(btn[BTN_DEPOSIT]),
        .core_req(core_req), .core_status(core_status),
        .core_rsp(core_rsp), .core_clk_en(core_clk_en),
        .led(led), .seg(seg), .dp(dp), .an(an)
    );

    task automatic check(input word_t actual, input word_t expected, input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic next_random_word(output word_t w);
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w[b]       = lfsr_state[0];       // One step per bit
        end
    endtask

    // Standard active-low hex font, {g,f,e,d,c,b,a}
    function automatic int seg_to_hex(input logic [6:0] s);
        case (s)
            7'h40: return 0;
            7'h79: return 1;
            7'h24: return 2;
            7'h30: return 3;
            7'h19: return 4;
            7'h12: return 5;
            7'h02: return 6;
            7'h78: return 7;
            7'h00: return 8;
            7'h10: return 9;
            7'h08: return 10;
            7'h03: return 11;
            7'h46: return 12;
            7'h21: return 13;
            7'h06: return 14;
            7'h0E: return 15;
            default: return -1;
        endcase
    endfunction

    function automatic int anode_index(input logic [3:0] a);
        case (a)
            4'b1110: return 0;
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;              // None or several lit
        endcase
    endfunction

    // One full scan rebuilds all four digits
    task automatic read_display(output word_t digits, output logic [3:0] dps);
        logic [3:0] seen;
        int         idx;
        int         nib;
        seen   = '0;
        digits = '0;
        dps    = '0;
        repeat (4 * SCAN_DIV) begin
            @(negedge clk);
            idx = anode_index(an);
            nib = seg_to_hex(seg);
            if (idx < 0) begin
                report_failure($sformatf("anode pattern %b does not select one digit", an));
            end else if (nib < 0) begin
                report_failure($sformatf("segment pattern %b is not a hex digit", seg));
            end else begin
                digits[idx*4 +: 4] = 4'(nib);
                dps[idx]           = ~dp;    // Decimal point active low
                seen[idx]          = 1'b1;
            end
        end
        if (seen != 4'hF) begin
            report_failure("display scan skipped a digit");
        end
    endtask

    task automatic press_button(input int idx, input int hold);
        @(posedge clk);
        btn[idx] <= 1'b1;
        repeat (hold) @(posedge clk);
        btn[idx] <= 1'b0;
        repeat (SETTLE) @(posedge clk);
    endtask

    task automatic core_write(input word_t addr, input word_t data);
        @(posedge clk);
        core_req.dmem.waddr <= addr[14:0];
        core_req.dmem.wdata <= data;
        core_req.dmem.we    <= 1'b1;
        @(posedge clk);
        core_req.dmem.we    <= 1'b0;
    endtask

    task automatic core_read(input word_t addr, input word_t expected);
        @(posedge clk);
        core_req.dmem.raddr <= addr[14:0];
        @(posedge clk);                       // Memory registers the word here
        @(negedge clk);
        check(core_rsp.dmem_data, expected, "core data read");
    endtask

    task automatic load_stim();
        int    fd;
        int    code;
        int    op_v;
        word_t sw_v;
        word_t exp_v;
        string line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            report_failure("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%h %h %h", op_v, sw_v, exp_v) == 3) begin
                        op_col.push_back(op_v);
                        sw_col.push_back(sw_v);
                        exp_col.push_back(exp_v);
                    end else begin
                        report_failure("malformed line in the stimulus file");
                    end
                end
            end
            $fclose(fd);
            n_lines = op_col.size();
        end
    endtask

    task automatic run_line(input int i);
        int         op_v;
        word_t      sw_v;
        word_t      exp_v;
        word_t      digits;
        word_t      data;
        logic [3:0] dps;
        int         count;
        op_v  = op_col[i];
        sw_v  = sw_col[i];
        exp_v = exp_col[i];
        @(posedge clk);
        sw <= sw_v;                           // Address or data for this line
        case (op_v)
            OP_CORE_WR: begin
                next_random_word(data);
                core_write(sw_v, data);
                dmem_model[sw_v] = data;
            end
            OP_CORE_RD: begin
                if (dmem_model.exists(sw_v)) begin
                    core_read(sw_v, dmem_model[sw_v]);
                end else begin
                    report_failure("stimulus reads a word the core never wrote");
                end
            end
            OP_ENTER, OP_TOGGLE: begin
                press_button(BTN_MODE, SHORT_HOLD);
                read_display(digits, dps);
                check({12'h000, dps}, exp_v, "panel decimal points");
                check(word_t'(core_clk_en), 16'h0000, "core clock enable in panel mode");
            end
            OP_EXIT: begin
                press_button(BTN_MODE, LONG_HOLD);
                read_display(digits, dps);
                check(digits, CORE_PC, "core status digits");
                check({12'h000, dps}, {12'h000, CORE_DP}, "core status points");
                check(led, exp_v, "LED register after exit");
                check(word_t'(core_clk_en), 16'h0001, "core clock enable after exit");
            end
            OP_EXAMINE, OP_SETADDR: begin
                press_button(BTN_EXAMINE, SHORT_HOLD);
                read_display(digits, dps);
                check(digits, sw_v, "examined address");
                if (op_v == OP_EXAMINE) begin
                    check(led, exp_v, "examined word");
                end
            end
            OP_DEPOSIT: begin
                press_button(BTN_DEPOSIT, SHORT_HOLD);
                read_display(digits, dps);
                check(led, sw_v, "deposited word echo");
                check(digits, exp_v, "address after deposit");
            end
            OP_SPEED: begin
                press_button(BTN_SPEED, SHORT_HOLD);
                count = 0;
                repeat (int'(sw_v)) begin     // Window is a multiple of SLOW_DIV
                    @(negedge clk);
                    if (core_clk_en) begin
                        count++;
                    end
                end
                check(word_t'(count), exp_v, "slow enables in window");
            end
            default: report_failure($sformatf("unknown stimulus op %0d", op_v));
        endcase
    endtask

    initial begin
        reset       = 1'b1;
        sw          = '0;
        btn         = '0;
        core_req    = '0;
        core_status = {CORE_PC, CORE_DP};
        load_stim();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        if (n_lines == 0) begin
            report_failure("no stimulus lines were run");
        end
        repeat (5) @(posedge clk);
        errors += dut0.panel.props0.fail_count;
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // Watchdog, budget scales with stim length
    initial begin
        wait (n_lines != 0);
        repeat (n_lines * CYCLES_PER_LINE + 100) @(posedge clk);
        $display("Watchdog expired before the stimulus finished");
        $display("Checks: %0d  Errors: %0d", checks, errors + 1);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verif/panel_stim.txt ====
# Columns (hex): op sw expected
# op 0 core write, 1 core read, 2 enter, 3 toggle, 4 exit, 5 examine, 6 deposit, 7 set address, 8 speed
0 0010 0000
0 0011 0000
0 0012 0000
1 0011 0000
1 0010 0000
1 0012 0000
2 0000 0004
7 0020 0000
6 1111 0021
6 2222 0022
6 3333 0023
5 0020 1111
5 0021 2222
5 0022 3333
3 0000 0008
7 0021 0000
6 abcd 0022
5 0021 abcd
3 0000 0004
5 0021 2222
7 8000 0000
6 beef 8001
5 8001 8001
4 0000 beef
1 0010 0000
8 0020 0008

// ==== list.f ====
source/panel_pkg.sv
source/button_debouncer.sv
source/run_control.sv
source/front_panel.sv
source/bus_router.sv
source/word_memory.sv
source/io_registers.sv
source/sevenseg_scan.sv
source/panel_top.sv
verif/panel_props.sv
verif/panel_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= panel_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) verif/panel_stim.txt
	./$(SIM_BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
